//--- sim.f
hdl/seq_pkg.sv
hdl/cmd_fifo.sv
hdl/time_base.sv
hdl/scheduler.sv
hdl/bus_unit.sv
hdl/seq_top.sv
bench/clk_gen.sv
bench/seq_assertions.sv
bench/seq_checker.sv
bench/tb_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_top
FILELIST  = sim.f
SRCS      = $(wildcard hdl/*.sv bench/*.sv)
BIN       = obj_dir/V$(TOP)
LOG       = sim.log

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/V%: $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "RESULT: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- bench/tb_top.sv
`timescale 1ns/100ps

module tb_top;

  logic                clk;
  logic                rst;
  logic                cmd_push;
  seq_pkg::sched_cmd_t cmd_in;
  logic                cmd_full;
  seq_pkg::bus_req_t   bus;
  logic [31:0]         current_time;
  logic [31:0]         adc_value;
  logic [31:0]         dac_value;
  logic [31:0]         xbar_value;
  logic                adc_busy;
  logic                dac_busy;
  logic                xbar_busy;
  int                  error_count;
  int                  strobe_count;
  int                  pending;
  logic [31:0]         seed;

  clk_gen u_clk_gen (.clk(clk), .rst(rst));

  seq_top u_seq_top (.*);

  seq_checker u_seq_checker (.*);

  // lcg step, advances the shared seed
  function automatic logic [31:0] rand_word();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // random command, unit 0 loads land a little ahead of the present time
  function automatic seq_pkg::sched_cmd_t make_cmd(input bit timed, input logic [7:0] busy_mask);
    seq_pkg::sched_cmd_t c;
    seq_pkg::bus_addr_u  a;
    logic [31:0]         r;
    r = rand_word();
    a.fields.unit    = r[31:30];
    a.fields.reg_sel = (r[31:30] == 2'd0 && r[29:27] != 3'd0) ? 14'd0 : r[29:16];
    c.addr       = a.raw;
    c.data       = rand_word();
    c.data[7:0]  = c.data[7:0] & busy_mask;
    if (a.fields.unit == seq_pkg::UNIT_TIME) begin
      c.data = current_time + {22'd0, c.data[9:0]};
    end
    c.issue_time = timed ? current_time + {24'd0, r[7:0]} : 32'd0;
    return c;
  endfunction

  task automatic push_burst(input int n, input bit timed, input logic [7:0] busy_mask,
                            input int gap);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      cmd_push <= 1'b1;
      cmd_in   <= make_cmd(timed, busy_mask);
      repeat (gap) begin
        @(posedge clk);
        cmd_push <= 1'b0;
      end
    end
    @(posedge clk);
    cmd_push <= 1'b0;
  endtask

  // reset has to assert first and then release
  task automatic wait_reset(output bit ok);
    int waited;
    bit seen;
    waited = 0;
    seen   = 1'b0;
    while (!(seen && rst === 1'b0) && waited < 100) begin
      @(posedge clk);
      if (rst === 1'b1) begin
        seen = 1'b1;
      end
      waited++;
    end
    ok = seen && (rst === 1'b0);
    if (!ok) begin
      $display("timeout: reset never released");
    end
  endtask

  // drained means no strobe for 400 cycles
  task automatic wait_drain(output bit ok);
    int quiet;
    int waited;
    quiet  = 0;
    waited = 0;
    while (quiet < 400 && waited < 20000) begin
      @(posedge clk);
      quiet = bus.en ? 0 : quiet + 1;
      waited++;
    end
    ok = (quiet >= 400);
    if (!ok) begin
      $display("timeout: command queue did not drain");
    end
  endtask

  initial begin
    bit ok;
    int asrt_errors;
    int total;
    cmd_push = 1'b0;
    cmd_in   = '0;
    seed     = 32'h137a;
    wait_reset(ok);
    // immediate commands, units never busy
    if (ok) begin
      push_burst(6, 1'b0, 8'h00, 0);
      wait_drain(ok);
    end
    // timed commands with short busy periods
    if (ok) begin
      push_burst(10, 1'b1, 8'h0f, 3);
      wait_drain(ok);
    end
    // long burst overruns the fifo, later pushes are dropped
    if (ok) begin
      push_burst(14, 1'b0, 8'h3f, 0);
      wait_drain(ok);
    end
    if (ok) begin
      push_burst(8, 1'b1, 8'h07, 1);
      wait_drain(ok);
    end
    asrt_errors = u_seq_top.u_scheduler.u_seq_assertions.fail_count;
    total = error_count + asrt_errors + pending;
    $display("strobes %0d, checker errors %0d, assertion errors %0d, unissued commands %0d",
             strobe_count, error_count, asrt_errors, pending);
    if (ok && total == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- bench/seq_checker.sv
`timescale 1ns/100ps

module seq_checker (
  input  logic                clk,
  input  logic                rst,
  input  logic                cmd_push,
  input  seq_pkg::sched_cmd_t cmd_in,
  input  logic                cmd_full,
  input  seq_pkg::bus_req_t   bus,
  input  logic [31:0]         current_time,
  input  logic [31:0]         adc_value,
  input  logic [31:0]         dac_value,
  input  logic [31:0]         xbar_value,
  input  logic                adc_busy,
  input  logic                dac_busy,
  input  logic                xbar_busy,
  output int                  error_count,
  output int                  strobe_count,
  output int                  pending
);

  // reference scheduler states
  localparam int S_FETCH     = 0;
  localparam int S_WAIT      = 1;
  localparam int S_EXEC      = 2;
  localparam int S_EXEC_WAIT = 3;

  // accepted commands not yet issued, head is the one in flight
  seq_pkg::sched_cmd_t ref_q [$];
  int          errors  = 0;
  int          strobes = 0;
  int          pend    = 0;
  int          fifo_cnt;
  int          st;
  logic [31:0] exp_time;
  logic [31:0] exp_val [1:3];
  logic [7:0]  exp_cnt [1:3];
  bit          written [1:3];
  string       unit_names [3] = '{"adc", "dac", "xbar"};

  assign error_count  = errors;
  assign strobe_count = strobes;
  assign pending      = pend;

  // head command may go out now: time reached or zero, units idle unless unit 0
  function automatic bit release_ok(input seq_pkg::sched_cmd_t c, input logic [31:0] now,
                                    input logic busy);
    seq_pkg::bus_addr_u a;
    a.raw = c.addr;
    return ((c.issue_time == 32'd0) || (c.issue_time <= now))
        && (!busy || (a.fields.unit == seq_pkg::UNIT_TIME));
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  // samples pre-edge values, so DUT and stimulus are stable here
  always @(posedge clk) begin
    logic        busy_any;
    logic        exp_busy;
    logic        exp_full;
    logic        exp_en;
    logic [31:0] got_val;
    logic        got_busy;
    int          u;
    seq_pkg::sched_cmd_t head;
    seq_pkg::bus_addr_u  head_addr;
    busy_any = adc_busy | dac_busy | xbar_busy;
    if (rst) begin
      ref_q.delete();
      fifo_cnt = 0;
      st       = S_FETCH;
      exp_time = 32'd0;
      for (int k = 1; k <= 3; k++) begin
        exp_cnt[k] = 8'd0;
        written[k] = 1'b0;
      end
      check("bus.en", 32'd0, 32'(bus.en));
      check("bus.wr", 32'd0, 32'(bus.wr));
      check("cmd_full", 32'd0, 32'(cmd_full));
      check("current_time", 32'd0, current_time);
      check("busy_any", 32'd0, 32'(busy_any));
    end else begin
      exp_full = (fifo_cnt == seq_pkg::CMD_FIFO_DEPTH);
      // modelled busy state before this cycle's countdown
      exp_busy = (exp_cnt[1] != 8'd0) || (exp_cnt[2] != 8'd0) || (exp_cnt[3] != 8'd0);
      check("current_time", exp_time, current_time);
      check("cmd_full", 32'(exp_full), 32'(cmd_full));
      for (int k = 1; k <= 3; k++) begin
        got_val  = (k == 1) ? adc_value : ((k == 2) ? dac_value : xbar_value);
        got_busy = (k == 1) ? adc_busy : ((k == 2) ? dac_busy : xbar_busy);
        check({unit_names[k-1], "_busy"}, 32'(exp_cnt[k] != 8'd0), 32'(got_busy));
        if (written[k]) begin
          check({unit_names[k-1], "_value"}, exp_val[k], got_val);
        end
        if (exp_cnt[k] != 8'd0) begin
          exp_cnt[k] = exp_cnt[k] - 8'd1;
        end
      end
      exp_en = (st == S_EXEC) && release_ok(ref_q[0], exp_time, exp_busy);
      check("bus.en", 32'(exp_en), 32'(bus.en));
      check("bus.wr", 32'(exp_en), 32'(bus.wr));
      exp_time = exp_time + 32'd1;
      case (st)
        S_FETCH: begin
          if (fifo_cnt > 0) begin
            fifo_cnt--;
            st = S_WAIT;
          end
        end
        S_WAIT: st = S_EXEC;
        S_EXEC: begin
          if (exp_en) begin
            head = ref_q.pop_front();
            strobes++;
            check("bus.addr", 32'(head.addr), 32'(bus.addr.raw));
            check("bus.data", head.data, bus.data);
            head_addr.raw = head.addr;
            u = int'(head_addr.fields.unit);
            if (u == 0) begin
              // only the load register moves the time base
              if (head_addr.fields.reg_sel == seq_pkg::REG_TIME_LOAD) begin
                exp_time = head.data;
              end
            end else begin
              exp_val[u] = head.data;
              exp_cnt[u] = head.data[7:0];
              written[u] = 1'b1;
            end
            st = S_EXEC_WAIT;
          end
        end
        default: st = S_FETCH;
      endcase
      // a push on a full fifo is lost
      if (cmd_push && !exp_full) begin
        ref_q.push_back(cmd_in);
        fifo_cnt++;
      end
    end
    pend = ref_q.size();
  end

endmodule

//--- bench/seq_assertions.sv
`timescale 1ns/100ps

module seq_assertions (
  input logic clk,
  input logic rst,
  input logic cmd_rd_en,
  input logic en,
  input logic wr
);

  // failures seen so far, summed into the closing count
  int fail_count = 0;

  // every bus cycle is a write, en and wr move as a pair
  en_wr_pair: assert property (@(posedge clk) disable iff (rst) en == wr)
    else begin
      fail_count++;
      $error("bus en and wr differ");
    end

  // exec_wait always follows the strobe
  en_one_cycle: assert property (@(posedge clk) disable iff (rst) en |=> !en)
    else begin
      fail_count++;
      $error("bus en held longer than one cycle");
    end

  // fetch never repeats back to back
  rd_en_one_cycle: assert property (@(posedge clk) disable iff (rst) cmd_rd_en |=> !cmd_rd_en)
    else begin
      fail_count++;
      $error("cmd_rd_en high in two consecutive cycles");
    end

endmodule

bind scheduler seq_assertions u_seq_assertions (
  .clk       (clk),
  .rst       (rst),
  .cmd_rd_en (cmd_rd_en),
  .en        (bus.en),
  .wr        (bus.wr)
);

//--- bench/clk_gen.sv
`timescale 1ns/100ps

module clk_gen (
  output logic clk,
  output logic rst
);

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // rst rises just after time zero so the async reset edge is seen, held 8 cycles
  initial begin
    rst = 1'b0;
    #1 rst = 1'b1;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- hdl/seq_top.sv
`timescale 1ns/100ps

module seq_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                cmd_push,
  input  seq_pkg::sched_cmd_t cmd_in,
  output logic                cmd_full,
  output seq_pkg::bus_req_t   bus,
  output logic [31:0]         current_time,
  output logic [31:0]         adc_value,
  output logic [31:0]         dac_value,
  output logic [31:0]         xbar_value,
  output logic                adc_busy,
  output logic                dac_busy,
  output logic                xbar_busy
);

  logic                cmd_rd_en;
  seq_pkg::sched_cmd_t cmd_dout;
  logic                cmd_valid;
  logic                cmd_empty;
  logic                any_busy;

  // any busy unit stalls commands to units 1 to 3
  assign any_busy = adc_busy | dac_busy | xbar_busy;

  cmd_fifo u_cmd_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (cmd_push),
    .push_data (cmd_in),
    .full      (cmd_full),
    .rd_en     (cmd_rd_en),
    .dout      (cmd_dout),
    .valid     (cmd_valid),
    .empty     (cmd_empty)
  );

  scheduler u_scheduler (
    .clk          (clk),
    .rst          (rst),
    .current_time (current_time),
    .any_busy     (any_busy),
    .cmd_dout     (cmd_dout),
    .cmd_empty    (cmd_empty),
    .cmd_valid    (cmd_valid),
    .cmd_rd_en    (cmd_rd_en),
    .bus          (bus)
  );

  // unit 0
  time_base u_time_base (
    .clk          (clk),
    .rst          (rst),
    .bus          (bus),
    .current_time (current_time)
  );

  bus_unit #(.UNIT_ID(seq_pkg::UNIT_ADC)) u_adc (
    .clk   (clk),
    .rst   (rst),
    .bus   (bus),
    .value (adc_value),
    .busy  (adc_busy)
  );

  bus_unit #(.UNIT_ID(seq_pkg::UNIT_DAC)) u_dac (
    .clk   (clk),
    .rst   (rst),
    .bus   (bus),
    .value (dac_value),
    .busy  (dac_busy)
  );

  bus_unit #(.UNIT_ID(seq_pkg::UNIT_XBAR)) u_xbar (
    .clk   (clk),
    .rst   (rst),
    .bus   (bus),
    .value (xbar_value),
    .busy  (xbar_busy)
  );

endmodule

//--- hdl/bus_unit.sv
`timescale 1ns/100ps

module bus_unit #(
  parameter logic [1:0] UNIT_ID = seq_pkg::UNIT_ADC
) (
  input  logic              clk,
  input  logic              rst,
  input  seq_pkg::bus_req_t bus,
  output logic [31:0]       value,
  output logic              busy
);

  logic       hit;
  logic [7:0] busy_cnt;

  // any register of this unit takes the write
  assign hit = bus.en & bus.wr & (bus.addr.fields.unit == UNIT_ID);

  // latched write data
  always_ff @(posedge clk) begin
    if (hit) begin
      value <= bus.data;
    end
  end

  // busy period length comes from the low byte of the data
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy_cnt <= '0;
    end else if (hit) begin
      busy_cnt <= bus.data[7:0];
    end else if (busy_cnt != 8'd0) begin
      busy_cnt <= busy_cnt - 8'd1;
    end
  end

  // high for exactly data[7:0] cycles after the strobe
  assign busy = (busy_cnt != 8'd0);

endmodule

//--- hdl/scheduler.sv
`timescale 1ns/100ps

module scheduler (
  input  logic                clk,
  input  logic                rst,
  input  logic [31:0]         current_time,
  input  logic                any_busy,
  input  seq_pkg::sched_cmd_t cmd_dout,
  input  logic                cmd_empty,
  input  logic                cmd_valid,
  output logic                cmd_rd_en,
  output seq_pkg::bus_req_t   bus
);

  logic [3:0] state;
  logic [3:0] next_state;

  // command currently being issued
  seq_pkg::sched_cmd_t cmd_reg;
  seq_pkg::bus_addr_u  cmd_addr;

  logic load_cmd;
  logic issue;
  logic time_ok;
  logic busy_ok;

  assign cmd_addr.raw = cmd_reg.addr;

  // time zero means run at once, regardless of the time base
  assign time_ok = (cmd_reg.issue_time == 32'd0) | (cmd_reg.issue_time <= current_time);

  // time base writes bypass the busy gating
  assign busy_ok = ~any_busy | (cmd_addr.fields.unit == seq_pkg::UNIT_TIME);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= seq_pkg::ST_FETCH;
    end else begin
      state <= next_state;
    end
  end

  // next state and strobes, outputs are not registered
  always_comb begin
    next_state = state;
    cmd_rd_en  = 1'b0;
    load_cmd   = 1'b0;
    issue      = 1'b0;
    case (state)
      seq_pkg::ST_FETCH: begin
        // idle here while the fifo is empty
        if (!cmd_empty) begin
          cmd_rd_en  = 1'b1;
          next_state = seq_pkg::ST_FIFO_WAIT;
        end
      end
      seq_pkg::ST_FIFO_WAIT: begin
        if (cmd_valid) begin
          load_cmd   = 1'b1;
          next_state = seq_pkg::ST_EXEC;
        end
      end
      seq_pkg::ST_EXEC: begin
        // hold until the time has come and the units are free
        if (time_ok && busy_ok) begin
          issue      = 1'b1;
          next_state = seq_pkg::ST_EXEC_WAIT;
        end
      end
      seq_pkg::ST_EXEC_WAIT: begin
        // one spare cycle after the strobe
        next_state = seq_pkg::ST_FETCH;
      end
      default: begin
        // illegal one-hot code, recover to fetch
        next_state = seq_pkg::ST_FETCH;
      end
    endcase
  end

  // command register
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cmd_reg <= '0;
    end else if (load_cmd) begin
      cmd_reg <= cmd_dout;
    end
  end

  // bus address and data straight from the command register
  always_comb begin
    bus.addr = cmd_addr;
    bus.data = cmd_reg.data;
    bus.en   = issue;
    bus.wr   = issue;
  end

endmodule

//--- hdl/time_base.sv
`timescale 1ns/100ps

module time_base (
  input  logic              clk,
  input  logic              rst,
  input  seq_pkg::bus_req_t bus,
  output logic [31:0]       current_time
);

  logic load;

  // unit 0 write to the load register replaces the increment
  assign load = bus.en & bus.wr
              & (bus.addr.fields.unit == seq_pkg::UNIT_TIME)
              & (bus.addr.fields.reg_sel == seq_pkg::REG_TIME_LOAD);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      current_time <= '0;
    end else if (load) begin
      // loaded value shows up the cycle after the strobe
      current_time <= bus.data;
    end else begin
      // free running, wraps at 2^32
      current_time <= current_time + 32'd1;
    end
  end

endmodule

//--- hdl/cmd_fifo.sv
`timescale 1ns/100ps

module cmd_fifo (
  input  logic                clk,
  input  logic                rst,
  input  logic                push,
  input  seq_pkg::sched_cmd_t push_data,
  output logic                full,
  input  logic                rd_en,
  output seq_pkg::sched_cmd_t dout,
  output logic                valid,
  output logic                empty
);

  // command storage
  seq_pkg::sched_cmd_t mem [seq_pkg::CMD_FIFO_DEPTH];

  logic [seq_pkg::CMD_PTR_W-1:0] wr_ptr;
  logic [seq_pkg::CMD_PTR_W-1:0] rd_ptr;
  logic [seq_pkg::CMD_CNT_W-1:0] count;

  logic do_push;
  logic do_read;

  assign full  = (count == seq_pkg::CMD_CNT_W'(seq_pkg::CMD_FIFO_DEPTH));
  assign empty = (count == '0);

  // push on full and read on empty are dropped here
  assign do_push = push & ~full;
  assign do_read = rd_en & ~empty;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // head entry registered out, valid follows rd_en by one cycle
  always_ff @(posedge clk) begin
    if (do_read) begin
      dout <= mem[rd_ptr];
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      valid  <= 1'b0;
    end else begin
      valid <= do_read;
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous push and read leaves the count unchanged
      if (do_push && !do_read) begin
        count <= count + 1'b1;
      end else if (do_read && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- hdl/seq_pkg.sv
package seq_pkg;

  // command fifo depth in entries
  localparam int CMD_FIFO_DEPTH = 8;
  // pointer and occupancy widths derived from the depth
  localparam int CMD_PTR_W = $clog2(CMD_FIFO_DEPTH);
  localparam int CMD_CNT_W = CMD_PTR_W + 1;

  // unit numbers, top two bits of the bus address
  localparam logic [1:0] UNIT_TIME = 2'd0;
  localparam logic [1:0] UNIT_ADC  = 2'd1;
  localparam logic [1:0] UNIT_DAC  = 2'd2;
  localparam logic [1:0] UNIT_XBAR = 2'd3;

  // register inside unit 0 that reloads the time base
  localparam logic [13:0] REG_TIME_LOAD = 14'd0;

  // scheduler fsm, one-hot
  localparam logic [3:0] ST_FETCH     = 4'b0001;
  localparam logic [3:0] ST_FIFO_WAIT = 4'b0010;
  localparam logic [3:0] ST_EXEC      = 4'b0100;
  localparam logic [3:0] ST_EXEC_WAIT = 4'b1000;

  // one 80-bit command word as pushed by the host
  typedef struct packed {
    logic [31:0] issue_time;
    logic [31:0] data;
    logic [15:0] addr;
  } sched_cmd_t;

  // decoded view of a bus address
  typedef struct packed {
    logic [1:0]  unit;
    logic [13:0] reg_sel;
  } bus_addr_fields_t;

  typedef union packed {
    logic [15:0]      raw;
    bus_addr_fields_t fields;
  } bus_addr_u;

  // internal bus, en and wr strobe for one cycle per command
  typedef struct packed {
    bus_addr_u   addr;
    logic [31:0] data;
    logic        en;
    logic        wr;
  } bus_req_t;

endpackage
